/* thermal_cam.f */
thermal_cam_pkg.sv
int16_to_float.sv
float_frame_store.sv
pixel_processor.sv
cam_sequencer.sv
thermal_cam_top.sv
tb_clock.sv
tb_i2c_camera_model.sv
tb_thermal_cam.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the thermal camera testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_thermal_cam -f thermal_cam.f -o sim_thermal_cam

./obj_dir/sim_thermal_cam > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb_thermal_cam.sv */
// Thermal camera frame engine testbench
module tb_thermal_cam;
    timeunit 1ns;
    timeprecision 1ps;

    import thermal_cam_pkg::*;

    // Per frame about eight cycles a byte, four a pixel and three a readback
    localparam int frame_cycles   = frame_bytes * 8 + pixel_count * 7;
    // Two frames plus polls and a wide margin
    localparam int timeout_cycles = 10 * frame_cycles + 20000;

    logic        clk;
    logic        reset;
    i2c_req_t    i2c_req;
    i2c_rsp_t    i2c_rsp;
    pix_addr_t   rd_addr = '0;
    logic [31:0] rd_data;
    logic        frame_ready;
    logic        error;
    int          cycle_count = 0;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    tb_i2c_camera_model u_camera (
        .clk   (clk),
        .reset (reset),
        .req   (i2c_req),
        .rsp   (i2c_rsp)
    );

    thermal_cam_top i_dut (
        .clk         (clk),
        .reset       (reset),
        .i2c_req     (i2c_req),
        .i2c_rsp     (i2c_rsp),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .frame_ready (frame_ready),
        .error       (error)
    );

    // Hung run guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_count);
            $display("STATUS: FAIL");
            $fatal(1);
        end
    end

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    // Sign, 127 plus leading-one position, bits below it left aligned
    function automatic logic [31:0] float_of_int16(input logic [15:0] raw);
        int          value;
        int          mag;
        int          top;
        logic [31:0] frac;
        value = int'($signed(raw));
        if (value == 0) begin
            return 32'h0000_0000;
        end
        mag = (value < 0) ? -value : value;
        top = 0;
        while ((mag >> (top + 1)) != 0) begin
            top++;
        end
        frac = 32'(mag << (23 - top));
        return {value < 0, 8'(127 + top), frac[22:0]};
    endfunction

    // Data registered one edge after the address and sampled on the next
    task automatic read_word(input int n, output logic [31:0] word);
        @(posedge clk);
        rd_addr <= pix_addr_t'(n);
        @(posedge clk);
        @(posedge clk);
        word = rd_data;
    endtask

    task automatic wait_frame();
        while (frame_ready) @(posedge clk);
        while (!frame_ready) @(posedge clk);
    endtask

    // ------------------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------------------
    task automatic verify_reset_state();
        @(posedge clk);
        while (reset) @(posedge clk);
        assert (frame_ready === 1'b1) else report_error("frame_ready not high after reset");
        assert (i2c_req.enable === 1'b0 && i2c_req.restart === 1'b0)
            else report_error("enable or restart high after reset");
        assert (error === 1'b0) else report_error("error high after reset");
    endtask

    // Control, configuration and status clear writes
    task automatic compare_config_writes();
        logic [7:0] expected [12] = '{8'h80, 8'h0D, 8'h19, 8'h01, 8'h80, 8'h0F,
                                     8'h00, 8'h00, 8'h80, 8'h00, 8'h00, 8'h30};
        while (u_camera.wr_log.size() < 12) @(posedge clk);
        for (int i = 0; i < 12; i++) begin
            assert (u_camera.wr_log[i] == {7'h33, expected[i]})
                else report_error($sformatf("write %0d logged %h, expected %h", i,
                                            u_camera.wr_log[i], {7'h33, expected[i]}));
        end
    endtask

    // Not-ready poll repeats the status address before the frame address
    task automatic confirm_poll_retry();
        logic [7:0] expected [6] = '{8'h80, 8'h00, 8'h80, 8'h00, 8'h04, 8'h00};
        while (u_camera.wr_log.size() < 18) @(posedge clk);
        for (int i = 0; i < 6; i++) begin
            assert (u_camera.wr_log[12 + i] == {7'h33, expected[i]})
                else report_error($sformatf("write %0d logged %h, expected %h", 12 + i,
                                            u_camera.wr_log[12 + i], {7'h33, expected[i]}));
        end
    endtask

    task automatic read_back_frame(input int frame_no);
        logic [31:0] got;
        logic [31:0] expected;
        logic [15:0] raw;
        wait_frame();
        assert (u_camera.frame_count == frame_no)
            else report_error($sformatf("frame count %0d, expected %0d",
                                        u_camera.frame_count, frame_no));
        for (int n = 0; n < pixel_count; n++) begin
            raw      = {u_camera.frame_data[2 * n], u_camera.frame_data[2 * n + 1]};
            expected = float_of_int16(raw);
            read_word(n, got);
            assert (got == expected)
                else report_error($sformatf("pixel %0d raw %h read %h, expected %h",
                                            n, raw, got, expected));
        end
        // Forced corner pixels against fixed encodings
        read_word(0, got);
        assert (got == 32'h0000_0000) else report_error($sformatf("zero pixel read %h", got));
        read_word(1, got);
        assert (got == 32'hC700_0000) else report_error($sformatf("-32768 pixel read %h", got));
    endtask

    task automatic expect_nack_stop();
        u_camera.arm_nack();
        while (!error) @(posedge clk);
        repeat (40) begin
            @(posedge clk);
            assert (i2c_req.enable === 1'b0 && error === 1'b1)
                else report_error("enable high or error low after a nack");
        end
    endtask

    initial begin
        u_camera.schedule_poll(1'b0);
        u_camera.schedule_poll(1'b1);
        verify_reset_state();
        compare_config_writes();
        confirm_poll_retry();
        read_back_frame(1);
        u_camera.schedule_poll(1'b1);
        read_back_frame(2);
        expect_nack_stop();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

/* tb_i2c_camera_model.sv */
// I2C byte engine and sensor model
module tb_i2c_camera_model (
    input  logic                      clk,
    input  logic                      reset,
    input  thermal_cam_pkg::i2c_req_t req,
    output thermal_cam_pkg::i2c_rsp_t rsp
);
    timeunit 1ns;
    timeprecision 1ps;

    import thermal_cam_pkg::*;

    // Response lines
    logic        ack = 1'b0;
    logic        nack = 1'b0;
    logic        idle = 1'b0;
    logic [7:0]  rx_byte = 8'h00;
    logic [1:0]  idle_cnt = 2'd0;

    // Written bytes as {chip address, byte}, oldest first
    logic [14:0] wr_log [$];
    // Latest frame, MSB of pixel n at 2n
    logic [7:0]  frame_data [frame_bytes];
    int          frame_count = 0;
    // Ready answer per status poll, not ready once empty
    bit          ready_sched [$];
    bit          nack_armed = 1'b0;
    bit          poll_ready = 1'b0;
    // Last two written bytes, the register address of a following read
    logic [15:0] reg_addr = 16'h0000;
    int          read_idx = 0;

    assign rsp = '{idle: idle, ack: ack, nack: nack, rx_byte: rx_byte};

    task automatic schedule_poll(input bit ready);
        ready_sched.push_back(ready);
    endtask

    task automatic arm_nack();
        nack_armed = 1'b1;
    endtask

    // Random pixels, then a zero pixel and a -32768 pixel at the front
    task automatic new_frame();
        for (int i = 0; i < frame_bytes; i++) begin
            frame_data[i] = 8'($urandom);
        end
        frame_data[0] = 8'h00;
        frame_data[1] = 8'h00;
        frame_data[2] = 8'h80;
        frame_data[3] = 8'h00;
        frame_count++;
    endtask

    // ------------------------------------------------------------------------
    // Bookkeeping for one byte
    // ------------------------------------------------------------------------
    task automatic serve_byte(output logic [7:0] data);
        data = 8'h00;
        if (!req.read_write) begin
            wr_log.push_back({req.chip_addr, req.tx_byte});
            reg_addr = {reg_addr[7:0], req.tx_byte};
            read_idx = 0;
        end else begin
            if (reg_addr == 16'h8000) begin
                if (read_idx == 0) begin
                    poll_ready = (ready_sched.size() > 0) ? ready_sched.pop_front() : 1'b0;
                end else begin
                    // Ready flag sits in bit 3 of the second status byte
                    data = poll_ready ? 8'h08 : 8'h00;
                end
            end else if (reg_addr == 16'h0400) begin
                if (read_idx == 0) begin
                    new_frame();
                end
                data = frame_data[read_idx];
            end
            read_idx++;
        end
    endtask

    // Byte engine, ack high two cycles then low two
    initial begin
        logic [7:0] data;
        void'($urandom(32'hddd1227b));
        forever begin
            @(posedge clk);
            if (!reset && req.enable) begin
                repeat (2) @(posedge clk);
                // No byte if enable dropped meanwhile
                if (req.enable) begin
                    serve_byte(data);
                    rx_byte <= data;
                    if (nack_armed) begin
                        nack_armed = 1'b0;
                        nack <= 1'b1;
                    end else begin
                        ack <= 1'b1;
                    end
                    repeat (2) @(posedge clk);
                    ack  <= 1'b0;
                    nack <= 1'b0;
                    @(posedge clk);
                end
            end
        end
    end

    // Idle two cycles after enable falls
    always @(posedge clk) begin
        if (req.enable) begin
            idle     <= 1'b0;
            idle_cnt <= 2'd0;
        end else if (idle_cnt != 2'd2) begin
            idle_cnt <= idle_cnt + 2'd1;
        end else begin
            idle <= 1'b1;
        end
    end

endmodule

/* tb_clock.sv */
// Testbench clock and reset
module tb_clock (
    output logic clk,
    output logic reset
);
    timeunit 1ns;
    timeprecision 1ps;

    logic reset_r = 1'b1;

    assign reset = reset_r;

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held over the first three rising edges
    initial begin
        repeat (3) @(posedge clk);
        reset_r <= 1'b0;
    end

endmodule

/* thermal_cam_top.sv */
// Thermal camera frame engine
module thermal_cam_top (
    input  logic                        clk,
    input  logic                        reset,
    output thermal_cam_pkg::i2c_req_t   i2c_req,
    input  thermal_cam_pkg::i2c_rsp_t   i2c_rsp,
    input  thermal_cam_pkg::pix_addr_t  rd_addr,
    output logic [31:0]                 rd_data,
    output logic                        frame_ready,
    output logic                        error
);
    import thermal_cam_pkg::*;

    // Raw bytes from the sequencer into the processor
    raw_wr_t raw_wr;
    logic    raw_frame_ready;

    // Converted floats into the frame store
    pix_wr_t pix_wr;

    // Sensor command and frame read steps
    cam_sequencer u_sequencer (
        .clk             (clk),
        .reset           (reset),
        .i2c_rsp         (i2c_rsp),
        .proc_done       (frame_ready),
        .i2c_req         (i2c_req),
        .raw_wr          (raw_wr),
        .raw_frame_ready (raw_frame_ready),
        .error           (error)
    );

    // int16 to float walk over the raw frame
    pixel_processor u_processor (
        .clk             (clk),
        .reset           (reset),
        .raw_wr          (raw_wr),
        .raw_frame_ready (raw_frame_ready),
        .pix_wr          (pix_wr),
        .proc_done       (frame_ready)
    );

    // Host-readable float frame
    float_frame_store u_store (
        .clk     (clk),
        .pix_wr  (pix_wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* cam_sequencer.sv */
// Sensor command sequencer
module cam_sequencer (
    input  logic                       clk,
    input  logic                       reset,
    input  thermal_cam_pkg::i2c_rsp_t  i2c_rsp,
    input  logic                       proc_done,
    output thermal_cam_pkg::i2c_req_t  i2c_req,
    output thermal_cam_pkg::raw_wr_t   raw_wr,
    output logic                       raw_frame_ready,
    output logic                       error
);
    import thermal_cam_pkg::*;

    seq_state_t state;
    seq_state_t step_next;
    logic [1:0] ack_hist;
    logic [1:0] nack_hist;
    logic       ack_rise;
    logic       nack_rise;
    logic       bus_free;
    logic       status_ready;
    raw_addr_t  byte_cnt;

    // Byte to send in each write step
    function automatic logic [7:0] tx_for(seq_state_t s);
        case (s)
            ctrl_adr_1:      return ctrl_write[31:24];
            ctrl_adr_2:      return ctrl_write[23:16];
            ctrl_data_1:     return ctrl_write[15:8];
            ctrl_data_2:     return ctrl_write[7:0];
            conf_adr_1:      return conf_write[31:24];
            conf_adr_2:      return conf_write[23:16];
            conf_data_1:     return conf_write[15:8];
            conf_data_2:     return conf_write[7:0];
            rst_stat_adr_1:  return stat_clear[31:24];
            rst_stat_adr_2:  return stat_clear[23:16];
            rst_stat_data_1: return stat_clear[15:8];
            rst_stat_data_2: return stat_clear[7:0];
            poll_adr_1:      return status_reg[15:8];
            poll_adr_2:      return status_reg[7:0];
            pix_adr_1:       return frame_reg[15:8];
            pix_adr_2:       return frame_reg[7:0];
            default:         return 8'h00;
        endcase
    endfunction

    // Rising edges of ack and nack, older sample in bit 1
    assign ack_rise  = (ack_hist == 2'b01);
    assign nack_rise = (nack_hist == 2'b01);

    // Engine has finished its stop or restart
    assign bus_free  = i2c_rsp.idle && !i2c_req.enable;
    assign step_next = seq_state_t'(state + 5'd1);
    assign error     = (state == i2c_error);

    always_ff @(posedge clk) begin
        if (reset) begin
            state           <= start;
            i2c_req         <= '0;
            ack_hist        <= '0;
            nack_hist       <= '0;
            byte_cnt        <= '0;
            raw_wr.valid    <= 1'b0;
            raw_frame_ready <= 1'b0;
        end else begin
            ack_hist        <= {ack_hist[0], i2c_rsp.ack};
            nack_hist       <= {nack_hist[0], i2c_rsp.nack};
            raw_wr.valid    <= 1'b0;
            raw_frame_ready <= 1'b0;

            // Any failed byte ends the run
            if (nack_rise && state != i2c_error) begin
                state <= i2c_error;
            end else begin
                case (state)
                    start: begin
                        i2c_req.chip_addr <= cam_chip_addr;
                        state             <= ctrl_adr_1;
                    end

                    // Single written bytes, one step per ack
                    ctrl_adr_1, ctrl_adr_2, ctrl_data_1, ctrl_data_2,
                    conf_adr_1, conf_adr_2, conf_data_1, conf_data_2,
                    rst_stat_adr_1, rst_stat_adr_2, rst_stat_data_1, rst_stat_data_2,
                    poll_adr_1, poll_adr_2, pix_adr_1, pix_adr_2: begin
                        i2c_req.enable     <= 1'b1;
                        i2c_req.restart    <= 1'b0;
                        i2c_req.read_write <= 1'b0;
                        i2c_req.tx_byte    <= tx_for(state);
                        if (ack_rise) state <= step_next;
                    end

                    // Stop after a register write
                    ctrl_done, conf_done, rst_stat_done: begin
                        i2c_req.enable  <= 1'b0;
                        i2c_req.restart <= 1'b0;
                        if (bus_free) state <= step_next;
                    end

                    // Restart into read mode
                    poll_switch, pix_switch: begin
                        i2c_req.enable     <= 1'b0;
                        i2c_req.restart    <= 1'b1;
                        i2c_req.read_write <= 1'b1;
                        byte_cnt           <= '0;
                        if (bus_free) state <= step_next;
                    end

                    poll_byte_1: begin
                        i2c_req.enable <= 1'b1;
                        if (ack_rise) state <= poll_byte_2;
                    end

                    // Second status byte carries the ready flag
                    poll_byte_2: begin
                        if (ack_rise) begin
                            status_ready <= i2c_rsp.rx_byte[status_ready_bit];
                            state        <= poll_check;
                        end
                    end

                    // Wait for idle, then read the frame or poll again
                    poll_check: begin
                        i2c_req.enable  <= 1'b0;
                        i2c_req.restart <= 1'b0;
                        if (bus_free) begin
                            if (!status_ready) begin
                                state <= poll_adr_1;
                            end else if (proc_done) begin
                                state <= pix_adr_1;
                            end
                        end
                    end

                    pix_byte: begin
                        i2c_req.enable <= 1'b1;
                        if (ack_rise) begin
                            raw_wr.valid <= 1'b1;
                            raw_wr.addr  <= byte_cnt;
                            raw_wr.data  <= i2c_rsp.rx_byte;
                            state        <= pix_store;
                        end
                    end

                    // Count bytes, flag the frame after the last one
                    pix_store: begin
                        if (byte_cnt == raw_addr_t'(frame_bytes - 1)) begin
                            raw_frame_ready <= 1'b1;
                            state           <= pix_done;
                        end else begin
                            byte_cnt <= byte_cnt + 11'd1;
                            state    <= pix_byte;
                        end
                    end

                    // Back to the status clear for the next conversion
                    pix_done: begin
                        i2c_req.enable  <= 1'b0;
                        i2c_req.restart <= 1'b0;
                        if (bus_free) state <= rst_stat_adr_1;
                    end

                    // Error holds the bus released until reset
                    default: begin
                        i2c_req.enable  <= 1'b0;
                        i2c_req.restart <= 1'b0;
                        state           <= i2c_error;
                    end
                endcase
            end
        end
    end

endmodule

/* pixel_processor.sv */
// Raw frame to float conversion walk
module pixel_processor (
    input  logic                      clk,
    input  logic                      reset,
    input  thermal_cam_pkg::raw_wr_t  raw_wr,
    input  logic                      raw_frame_ready,
    output thermal_cam_pkg::pix_wr_t  pix_wr,
    output logic                      proc_done
);
    import thermal_cam_pkg::*;

    // Raw sensor bytes, MSB of pixel n at 2n
    logic [7:0]  raw_buf [frame_bytes];

    proc_state_t state;
    pix_addr_t   pix_idx;
    logic [15:0] int_word;
    logic [31:0] float_word;

    always_ff @(posedge clk) begin
        if (raw_wr.valid) raw_buf[raw_wr.addr] <= raw_wr.data;
    end

    // One-cycle converter
    int16_to_float u_conv (
        .clk       (clk),
        .int_in    (int_word),
        .float_out (float_word)
    );

    // Float goes to the store during the write step
    always_comb begin
        pix_wr.valid = (state == write);
        pix_wr.addr  = pix_idx;
        pix_wr.data  = float_word;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= wait_start;
            pix_idx   <= '0;
            proc_done <= 1'b1;
        end else begin
            case (state)
                wait_start: begin
                    pix_idx <= '0;
                    if (raw_frame_ready) begin
                        proc_done <= 1'b0;
                        state     <= load;
                    end
                end
                // Join MSB and LSB of the pixel
                load: begin
                    int_word <= {raw_buf[{pix_idx, 1'b0}], raw_buf[{pix_idx, 1'b1}]};
                    state    <= convert;
                end
                convert: begin
                    state <= write;
                end
                // Frame is complete once the last float is written
                write: begin
                    if (pix_idx == pix_addr_t'(pixel_count - 1)) proc_done <= 1'b1;
                    state <= next;
                end
                next: begin
                    pix_idx <= pix_idx + 10'd1;
                    state   <= proc_done ? wait_start : load;
                end
                default: begin
                    state <= wait_start;
                end
            endcase
        end
    end

endmodule

/* float_frame_store.sv */
// Float frame memory
module float_frame_store (
    input  logic                       clk,
    input  thermal_cam_pkg::pix_wr_t   pix_wr,
    input  thermal_cam_pkg::pix_addr_t rd_addr,
    output logic [31:0]                rd_data
);
    import thermal_cam_pkg::*;

    // One float per pixel
    logic [31:0] mem [pixel_count];

    // ------------------------------------------------------------------------
    // Write from the processor, registered host read
    // ------------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (pix_wr.valid) mem[pix_wr.addr] <= pix_wr.data;
        rd_data <= mem[rd_addr];
    end

endmodule

/* int16_to_float.sv */
// Signed int16 to float32 converter
module int16_to_float (
    input  logic        clk,
    input  logic [15:0] int_in,
    output logic [31:0] float_out
);
    logic        sign;
    logic [16:0] mag;
    logic [3:0]  top_bit;
    logic [4:0]  shift_amt;
    logic [39:0] shifted;

    // 17-bit magnitude so that -32768 stays positive
    assign sign = int_in[15];
    assign mag  = sign ? 17'(-{int_in[15], int_in}) : {1'b0, int_in};

    // Position of the leading one
    always_comb begin
        top_bit = '0;
        for (int i = 0; i < 16; i++) begin
            if (mag[i]) top_bit = 4'(i);
        end
    end

    // Leading one lands on bit 23, the rest is the mantissa
    assign shift_amt = 5'd23 - {1'b0, top_bit};
    assign shifted   = {23'b0, mag} << shift_amt;

    always_ff @(posedge clk) begin
        if (int_in == 16'h0000) begin
            float_out <= '0;
        end else begin
            float_out <= {sign, 8'd127 + {4'b0, top_bit}, shifted[22:0]};
        end
    end

endmodule

/* thermal_cam_pkg.sv */
// Thermal camera shared definitions
package thermal_cam_pkg;

    // Sensor bus address and frame geometry
    localparam logic [6:0] cam_chip_addr = 7'h33;
    localparam int frame_bytes = 1536;
    localparam int pixel_count = 768;

    // Ready flag inside the second status byte
    localparam int status_ready_bit = 3;

    // Register writes, sent MSB first: address high, address low, data high, data low
    localparam logic [31:0] ctrl_write = 32'h800D_1901;
    localparam logic [31:0] conf_write = 32'h800F_0000;
    localparam logic [31:0] stat_clear = 32'h8000_0030;

    // Register addresses for reads
    localparam logic [15:0] status_reg = 16'h8000;
    localparam logic [15:0] frame_reg  = 16'h0400;

    typedef logic [10:0] raw_addr_t;
    typedef logic [9:0]  pix_addr_t;

    // Step order matters, the sequencer advances to the next encoding
    typedef enum logic [4:0] {
        start,
        ctrl_adr_1, ctrl_adr_2, ctrl_data_1, ctrl_data_2, ctrl_done,
        conf_adr_1, conf_adr_2, conf_data_1, conf_data_2, conf_done,
        rst_stat_adr_1, rst_stat_adr_2, rst_stat_data_1, rst_stat_data_2, rst_stat_done,
        poll_adr_1, poll_adr_2, poll_switch, poll_byte_1, poll_byte_2, poll_check,
        pix_adr_1, pix_adr_2, pix_switch, pix_byte, pix_store, pix_done,
        i2c_error
    } seq_state_t;

    typedef enum logic [2:0] {
        wait_start,
        load,
        convert,
        write,
        next
    } proc_state_t;

    // Request to the I2C byte engine
    typedef struct packed {
        logic       enable;
        logic       restart;
        logic       read_write;
        logic [6:0] chip_addr;
        logic [7:0] tx_byte;
    } i2c_req_t;

    // Response from the I2C byte engine
    typedef struct packed {
        logic       idle;
        logic       ack;
        logic       nack;
        logic [7:0] rx_byte;
    } i2c_rsp_t;

    typedef struct packed {
        logic       valid;
        raw_addr_t  addr;
        logic [7:0] data;
    } raw_wr_t;

    typedef struct packed {
        logic        valid;
        pix_addr_t   addr;
        logic [31:0] data;
    } pix_wr_t;

endpackage
